// File: rv_decode.f
hdl/rv_decode_pkg.sv
hdl/fetch_unit.sv
hdl/instr_queue.sv
hdl/instruction_decoder.sv
hdl/decode_stage.sv
hdl/rv_decode_top.sv
bench/rv_decode_tb.sv

// File: Bender.yml
package:
  name: rv_decode

sources:
  - hdl/rv_decode_pkg.sv
  - hdl/fetch_unit.sv
  - hdl/instr_queue.sv
  - hdl/instruction_decoder.sv
  - hdl/decode_stage.sv
  - hdl/rv_decode_top.sv
  - target: test
    files:
      - bench/rv_decode_tb.sv

// File: bench/rv_decode_tb.sv
`timescale 1ns/10ps

module rv_decode_tb
    import rv_decode_pkg::*;
();

    localparam int              clk_period  = 100;
    localparam int              queue_depth = 4;
    localparam logic [xlen-1:0] reset_pc    = 32'h0000_1000;
    localparam logic [xlen-1:0] jump_pc     = 32'h0000_8000;
    localparam int              n_random    = 40;
    localparam int              total_words = 1 + 16 + n_random + 4 * queue_depth + 9;
    localparam int              fields_w    = funct7_w + funct3_w + 3 * reg_idx_w;

    // fifteen listed opcodes and one unlisted one at the top.
    localparam logic [79:0] dir_ops = {5'b11111, op_jal, op_branch, op_lui, op_auipc,
                                       op_op_fp, op_op_32, op_op, op_store_fp, op_store,
                                       op_system, op_jalr, op_imm_32, op_imm, op_load_fp,
                                       op_load};

    typedef struct packed {
        instr_type_e          itype;
        opcode_e              op;
        logic [funct7_w-1:0]  funct7;
        logic [funct3_w-1:0]  funct3;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      imm;
    } decoded_t;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic [xlen-1:0]      in_instr;
    logic                 in_ready;
    logic                 redirect;
    logic [xlen-1:0]      redirect_pc;
    logic                 stall;
    logic                 out_valid;
    logic [xlen-1:0]      out_pc;
    instr_type_e          out_type;
    opcode_e              out_opcode;
    logic [funct3_w-1:0]  out_funct3;
    logic [funct7_w-1:0]  out_funct7;
    logic [reg_idx_w-1:0] out_rs1;
    logic [reg_idx_w-1:0] out_rs2;
    logic [reg_idx_w-1:0] out_rd;
    logic [xlen-1:0]      out_imm;

    // scoreboard of accepted words and their predicted pcs.
    logic [xlen-1:0] exp_instr [$];
    logic [xlen-1:0] exp_pc [$];
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] first_pc;
    logic [xlen-1:0] mon_pc;
    decoded_t        mon_exp;
    int              errors;
    int              checks;
    int              out_count;
    int              test_errors;
    int              sent;
    int              base_count;
    int              dropped;

    rv_decode_top #(
        .queue_depth (queue_depth),
        .reset_pc    (reset_pc)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_type    (out_type),
        .out_opcode  (out_opcode),
        .out_funct3  (out_funct3),
        .out_funct7  (out_funct7),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_rd      (out_rd),
        .out_imm     (out_imm)
    );

    always #(clk_period / 2) clk = ~clk;

    // expected decode from the rv32i field layout.
    function automatic decoded_t ref_decode(input logic [xlen-1:0] w);
        decoded_t        d;
        logic [xlen-1:0] sgn;
        sgn      = {xlen{w[31]}};
        d.op     = opcode_e'(w[6:2]);
        d.funct7 = w[31:25];
        d.funct3 = w[14:12];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.rd     = w[11:7];
        case (w[6:2])
            5'b00000, 5'b00001, 5'b00100, 5'b00110, 5'b11001, 5'b11100: d.itype = i_type;
            5'b01000, 5'b01001: d.itype = s_type;
            5'b01100, 5'b01110, 5'b10100: d.itype = r_type;
            5'b00101, 5'b01101: d.itype = u_type;
            5'b11000: d.itype = b_type;
            5'b11011: d.itype = j_type;
            default: d.itype = invalid_type;
        endcase
        case (d.itype)
            i_type: d.imm = (sgn << 12) | xlen'(w[31:20]);
            s_type: d.imm = (sgn << 12) | (xlen'(w[31:25]) << 5) | xlen'(w[11:7]);
            b_type: d.imm = (sgn << 12) | (xlen'(w[7]) << 11) | (xlen'(w[30:25]) << 5)
                            | (xlen'(w[11:8]) << 1);
            u_type: d.imm = w & 32'hffff_f000;
            j_type: d.imm = (sgn << 20) | (xlen'(w[19:12]) << 12) | (xlen'(w[20]) << 11)
                            | (xlen'(w[30:21]) << 1);
            default: d.imm = '0;
        endcase
        return d;
    endfunction

    task automatic check_type(input instr_type_e got, input instr_type_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: format got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_fields(input opcode_e got_op, input opcode_e exp_op,
                                input logic [fields_w-1:0] got_f,
                                input logic [fields_w-1:0] exp_f);
        checks++;
        if (got_op !== exp_op || got_f !== exp_f) begin
            errors++;
            $display("mismatch at %0t: opcode/fields got %h/%h expected %h/%h",
                     $time, got_op, got_f, exp_op, exp_f);
        end
    endtask

    task automatic check_word(input string what, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // tasks below start and end 1 ns after a rising edge.
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_word(input logic [xlen-1:0] w);
        while (!in_ready) begin
            idle(1);
        end
        in_valid = 1'b1;
        in_instr = w;
        exp_instr.push_back(w);
        exp_pc.push_back(next_pc);
        next_pc  = next_pc + 4;
        idle(1);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_instr.size() != 0 && n < 20 * queue_depth + 20) begin
            idle(1);
            n++;
        end
        if (exp_instr.size() != 0) begin
            errors++;
            $display("%0d words never came out by %0t", exp_instr.size(), $time);
        end
    endtask

    // words popped by the redirect edge still come out.
    // later ones are gone.
    task automatic redirect_to(input logic [xlen-1:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        idle(1);
        redirect = 1'b0;
        idle(2);
        dropped = exp_instr.size();
        exp_instr.delete();
        exp_pc.delete();
        next_pc = pc;
    endtask

    task automatic end_test(input string name);
        $display("%s finished, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    always @(negedge clk) begin
        if (rst_n && out_valid === 1'b1) begin
            if (exp_instr.size() == 0) begin
                errors++;
                $display("output with pc %h at %0t was not expected", out_pc, $time);
            end else begin
                mon_pc  = exp_pc.pop_front();
                mon_exp = ref_decode(exp_instr.pop_front());
                check_type(out_type, mon_exp.itype);
                check_fields(out_opcode, mon_exp.op,
                             {out_funct7, out_funct3, out_rs1, out_rs2, out_rd},
                             {mon_exp.funct7, mon_exp.funct3, mon_exp.rs1, mon_exp.rs2,
                              mon_exp.rd});
                check_word("imm", out_imm, mon_exp.imm);
                check_word("pc", out_pc, mon_pc);
                if (out_count == 0) begin
                    first_pc = out_pc;
                end
                out_count++;
            end
        end
    end

    initial begin
        #(clk_period * (200 * total_words + 20));
        $display("timeout, the run did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        errors      = 0;
        checks      = 0;
        out_count   = 0;
        test_errors = 0;
        next_pc     = reset_pc;
        void'($urandom(32'h94e48454));
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(1);

        checks++;
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            errors++;
            $display("wrong state after reset, out_valid %b in_ready %b", out_valid, in_ready);
        end
        send_word(32'h0123_4513);
        wait_drain();
        check_word("first pc", first_pc, reset_pc);
        end_test("test 1 reset state");

        for (int i = 0; i < 16; i++) begin
            send_word(($urandom() & 32'hffff_ff80) | {25'b0, dir_ops[i * 5 +: 5], 2'b11});
        end
        wait_drain();
        end_test("test 2 directed opcodes");

        for (int i = 0; i < n_random; i++) begin
            send_word($urandom());
            idle($urandom_range(3, 0));
        end
        wait_drain();
        end_test("test 3 random words");

        // hold the queue until in_ready drops.
        stall      = 1'b1;
        sent       = 0;
        base_count = out_count;
        while (in_ready && sent < 4 * queue_depth) begin
            send_word($urandom());
            sent++;
        end
        idle(3);
        if (in_ready || out_count != base_count) begin
            errors++;
            $display("stall did not hold, in_ready %b after %0d words, %0d outputs",
                     in_ready, sent, out_count - base_count);
        end
        stall = 1'b0;
        wait_drain();
        end_test("test 4 stall and drain");

        for (int i = 0; i < 3; i++) begin
            send_word($urandom());
        end
        stall = 1'b1;
        for (int i = 0; i < 2; i++) begin
            send_word($urandom());
        end
        redirect_to(jump_pc);
        stall = 1'b0;
        if (dropped == 0) begin
            errors++;
            $display("redirect at %0t discarded no pending words", $time);
        end
        for (int i = 0; i < 4; i++) begin
            send_word($urandom());
        end
        wait_drain();
        end_test("test 5 redirect");

        $display("outputs %0d, checks %0d, errors %0d", out_count, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hdl/rv_decode_top.sv
`timescale 1ns/10ps

module rv_decode_top
    import rv_decode_pkg::*;
#(
    parameter int              queue_depth = 4,
    parameter logic [xlen-1:0] reset_pc    = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [xlen-1:0]      in_instr,
    output logic                 in_ready,
    input  logic                 redirect,
    input  logic [xlen-1:0]      redirect_pc,
    input  logic                 stall,
    output logic                 out_valid,
    output logic [xlen-1:0]      out_pc,
    output instr_type_e          out_type,
    output opcode_e              out_opcode,
    output logic [funct3_w-1:0]  out_funct3,
    output logic [funct7_w-1:0]  out_funct7,
    output logic [reg_idx_w-1:0] out_rs1,
    output logic [reg_idx_w-1:0] out_rs2,
    output logic [reg_idx_w-1:0] out_rd,
    output logic [xlen-1:0]      out_imm
);

    logic            push;
    logic [xlen-1:0] push_instr;
    logic [xlen-1:0] push_pc;
    logic            flush;
    logic            full;
    logic            empty;
    logic            pop;
    logic [xlen-1:0] head_instr;
    logic [xlen-1:0] head_pc;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .full        (full),
        .in_ready    (in_ready),
        .push        (push),
        .push_instr  (push_instr),
        .push_pc     (push_pc),
        .flush       (flush)
    );

    instr_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_instr (push_instr),
        .push_pc    (push_pc),
        .pop        (pop),
        .flush      (flush),
        .head_instr (head_instr),
        .head_pc    (head_pc),
        .empty      (empty),
        .full       (full)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (empty),
        .head_instr (head_instr),
        .head_pc    (head_pc),
        .stall      (stall),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_type   (out_type),
        .out_opcode (out_opcode),
        .out_funct3 (out_funct3),
        .out_funct7 (out_funct7),
        .out_rs1    (out_rs1),
        .out_rs2    (out_rs2),
        .out_rd     (out_rd),
        .out_imm    (out_imm)
    );

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 empty,
    input  logic [xlen-1:0]      head_instr,
    input  logic [xlen-1:0]      head_pc,
    input  logic                 stall,
    output logic                 pop,
    output logic                 out_valid,
    output logic [xlen-1:0]      out_pc,
    output instr_type_e          out_type,
    output opcode_e              out_opcode,
    output logic [funct3_w-1:0]  out_funct3,
    output logic [funct7_w-1:0]  out_funct7,
    output logic [reg_idx_w-1:0] out_rs1,
    output logic [reg_idx_w-1:0] out_rs2,
    output logic [reg_idx_w-1:0] out_rd,
    output logic [xlen-1:0]      out_imm
);

    instr_type_e          dec_type;
    opcode_e              dec_opcode;
    logic [funct3_w-1:0]  dec_funct3;
    logic [funct7_w-1:0]  dec_funct7;
    logic [reg_idx_w-1:0] dec_rs1;
    logic [reg_idx_w-1:0] dec_rs2;
    logic [reg_idx_w-1:0] dec_rd;
    logic [xlen-1:0]      dec_imm;

    // decode the queue head directly.
    instruction_decoder u_decoder (
        .instr      (head_instr),
        .instr_type (dec_type),
        .opcode     (dec_opcode),
        .funct3     (dec_funct3),
        .funct7     (dec_funct7),
        .rs1        (dec_rs1),
        .rs2        (dec_rs2),
        .rd         (dec_rd),
        .imm        (dec_imm)
    );

    // take one word per cycle unless stalled.
    assign pop = ~empty & ~stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    // result registers only load on a pop.
    always_ff @(posedge clk) begin
        if (pop) begin
            out_pc     <= head_pc;
            out_type   <= dec_type;
            out_opcode <= dec_opcode;
            out_funct3 <= dec_funct3;
            out_funct7 <= dec_funct7;
            out_rs1    <= dec_rs1;
            out_rs2    <= dec_rs2;
            out_rd     <= dec_rd;
            out_imm    <= dec_imm;
        end
    end

endmodule

// File: hdl/instruction_decoder.sv
`timescale 1ns/10ps

module instruction_decoder
    import rv_decode_pkg::*;
(
    input  logic [xlen-1:0]      instr,
    output instr_type_e          instr_type,
    output opcode_e              opcode,
    output logic [funct3_w-1:0]  funct3,
    output logic [funct7_w-1:0]  funct7,
    output logic [reg_idx_w-1:0] rs1,
    output logic [reg_idx_w-1:0] rs2,
    output logic [reg_idx_w-1:0] rd,
    output logic [xlen-1:0]      imm
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // bits 1 to 0 are not checked.
    assign opcode = opcode_e'(instr[6:2]);

    // fixed rv32i field positions.
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // immediates, sign taken from bit 31.
    assign imm_i = {{(xlen - 12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(xlen - 12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(xlen - 13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(xlen - 21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // format from the major opcode.
    always_comb begin
        case (opcode)
            op_load, op_load_fp, op_imm, op_imm_32, op_jalr, op_system: begin
                instr_type = i_type;
            end
            op_store, op_store_fp: begin
                instr_type = s_type;
            end
            op_op, op_op_32, op_op_fp: begin
                instr_type = r_type;
            end
            op_auipc, op_lui: begin
                instr_type = u_type;
            end
            op_branch: begin
                instr_type = b_type;
            end
            op_jal: begin
                instr_type = j_type;
            end
            default: begin
                instr_type = invalid_type;
            end
        endcase
    end

    // r format and unknown opcodes carry no immediate.
    always_comb begin
        case (instr_type)
            i_type:  imm = imm_i;
            s_type:  imm = imm_s;
            b_type:  imm = imm_b;
            u_type:  imm = imm_u;
            j_type:  imm = imm_j;
            default: imm = '0;
        endcase
    end

endmodule

// File: hdl/instr_queue.sv
`timescale 1ns/10ps

module instr_queue
    import rv_decode_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  logic [xlen-1:0] push_instr,
    input  logic [xlen-1:0] push_pc,
    input  logic            pop,
    input  logic            flush,
    output logic [xlen-1:0] head_instr,
    output logic [xlen-1:0] head_pc,
    output logic            empty,
    output logic            full
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    logic [xlen-1:0]  instr_mem [queue_depth];
    logic [xlen-1:0]  pc_mem    [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(queue_depth));

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // show-ahead: head is read straight from storage.
    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap by compare, depth need not be a power of two.
                wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
    import rv_decode_pkg::*;
#(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic [xlen-1:0] in_instr,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            full,
    output logic            in_ready,
    output logic            push,
    output logic [xlen-1:0] push_instr,
    output logic [xlen-1:0] push_pc,
    output logic            flush
);

    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] base_pc;
    logic            pend;
    logic            accept;

    // the fetch register overflows only if it holds a word the queue cannot take.
    assign in_ready = ~(pend & full);
    assign accept   = in_valid & in_ready;

    // a word taken in the redirect cycle already starts at the new pc.
    assign base_pc = redirect ? redirect_pc : next_pc;

    // pending word goes out unless the queue is full or being flushed.
    assign push  = pend & ~full & ~redirect;
    assign flush = redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_pc <= reset_pc;
        end else if (accept) begin
            next_pc <= base_pc + xlen'(4);
        end else if (redirect) begin
            next_pc <= redirect_pc;
        end
    end

    // occupancy of the one-word fetch register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= 1'b0;
        end else if (accept) begin
            pend <= 1'b1;
        end else if (redirect || push) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_instr <= in_instr;
            push_pc    <= base_pc;
        end
    end

endmodule

// File: hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    // word, pc and immediate width.
    localparam int xlen = 32;

    // register index width.
    localparam int reg_idx_w = 5;

    // fixed field widths of an rv32i word.
    localparam int opcode_w = 5;
    localparam int funct3_w = 3;
    localparam int funct7_w = 7;

    // instruction format.
    // invalid_type marks a major opcode outside the table.
    typedef enum logic [2:0] {
        i_type       = 3'd0,
        b_type       = 3'd1,
        s_type       = 3'd2,
        u_type       = 3'd3,
        j_type       = 3'd4,
        r_type       = 3'd5,
        invalid_type = 3'd6
    } instr_type_e;

    // major opcode, instruction bits 6 to 2.
    typedef enum logic [opcode_w-1:0] {
        // i format.
        op_load     = 5'b00000,
        op_load_fp  = 5'b00001,
        op_imm      = 5'b00100,
        op_imm_32   = 5'b00110,
        op_jalr     = 5'b11001,
        op_system   = 5'b11100,
        // s format.
        op_store    = 5'b01000,
        op_store_fp = 5'b01001,
        // r format.
        op_op       = 5'b01100,
        op_op_32    = 5'b01110,
        op_op_fp    = 5'b10100,
        // u format.
        op_auipc    = 5'b00101,
        op_lui      = 5'b01101,
        // b format.
        op_branch   = 5'b11000,
        // j format.
        op_jal      = 5'b11011
    } opcode_e;

endpackage
